// File: isaPkg.sv
// ----------------------------------------------------------
// MIPS integer ISA constants, opcodes and function codes
// Instruction word with its R, I and J format views
// ----------------------------------------------------------
package isaPkg;

	localparam int dataWidth    = 32;
	localparam int regAddrWidth = 5;
	localparam int regCount     = 32;

	localparam logic [regAddrWidth-1:0] linkReg       = 5'd31; // Return address of JAL, JALR
	localparam logic [regAddrWidth-1:0] syscallArgReg = 5'd2;  // v0

	// REGIMM branch kind sits in the rt field
	localparam logic [regAddrWidth-1:0] rtBltz = 5'd0;
	localparam logic [regAddrWidth-1:0] rtBgez = 5'd1;

	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opRegimm  = 6'h01,
		opJ       = 6'h02,
		opJal     = 6'h03,
		opBeq     = 6'h04,
		opBne     = 6'h05,
		opBlez    = 6'h06,
		opBgtz    = 6'h07,
		opAddi    = 6'h08,
		opAddiu   = 6'h09,
		opSlti    = 6'h0a,
		opAndi    = 6'h0c,
		opOri     = 6'h0d,
		opXori    = 6'h0e,
		opLui     = 6'h0f,
		opLw      = 6'h23,
		opSw      = 6'h2b
	} opcodeT;

	// SPECIAL function field
	typedef enum logic [5:0] {
		fnSll     = 6'h00,
		fnSrl     = 6'h02,
		fnSra     = 6'h03,
		fnJr      = 6'h08,
		fnJalr    = 6'h09,
		fnSyscall = 6'h0c,
		fnAdd     = 6'h20,
		fnAddu    = 6'h21,
		fnSub     = 6'h22,
		fnSubu    = 6'h23,
		fnAnd     = 6'h24,
		fnOr      = 6'h25,
		fnXor     = 6'h26,
		fnNor     = 6'h27,
		fnSlt     = 6'h2a,
		fnSltu    = 6'h2b
	} functT;

	typedef struct packed {
		opcodeT                  opcode;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [regAddrWidth-1:0] rd;
		logic [4:0]              shamt;
		functT                   funct;
	} rFormatT;

	typedef struct packed {
		opcodeT                  opcode;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [15:0]             imm;
	} iFormatT;

	typedef struct packed {
		opcodeT      opcode;
		logic [25:0] target; // Word index inside the 256 MB region
	} jFormatT;

	typedef union packed {
		rFormatT r;
		iFormatT i;
		jFormatT j;
	} instrT;

endpackage

// File: pipePkg.sv
// ----------------------------------------------------------
// ALU operation codes, decode control and pipeline bundles
// ----------------------------------------------------------
package pipePkg;

	typedef enum logic [3:0] {
		aluPass = 4'd0, // Bubble, no operation
		aluAdd,
		aluAddu,
		aluSub,
		aluSubu,
		aluAnd,
		aluOr,
		aluXor,
		aluNor,
		aluSlt,
		aluSltu,
		aluSll,
		aluSrl,
		aluSra,
		aluLui
	} aluOpT;

	typedef struct packed {
		logic  regDst;   // Destination from rd
		logic  link;     // Writes return address
		logic  jump;
		logic  jumpReg;  // Target from rs
		logic  branch;
		logic  memRead;
		logic  memWrite;
		logic  memToReg;
		logic  aluSrc;   // Immediate as operand B
		logic  regWrite;
		logic  signExt;
		logic  syscall;
		aluOpT aluOp;
	} ctrlT;

	// Result on its way back to the register file
	typedef struct packed {
		logic                              valid;
		logic [isaPkg::regAddrWidth-1:0]   regAddr;
		logic [isaPkg::dataWidth-1:0]      data;
	} fwdT;

	// ----------------------------------------------------------
	// ID/EX bundle
	// ----------------------------------------------------------
	typedef struct packed {
		logic [isaPkg::dataWidth-1:0]      operandA;
		logic [isaPkg::dataWidth-1:0]      operandB;
		logic [isaPkg::dataWidth-1:0]      storeData;
		logic [isaPkg::regAddrWidth-1:0]   srcRegA;  // For EX forwarding
		logic [isaPkg::regAddrWidth-1:0]   srcRegB;
		logic [isaPkg::regAddrWidth-1:0]   destReg;
		logic                              doWriteback;
		logic                              memRead;
		logic                              memWrite;
		logic                              memToReg;
		aluOpT                             aluOp;
		logic                              aluSrc;
		logic [4:0]                        shamt;
	} idExT;

	localparam logic [isaPkg::dataWidth-1:0] linkOffset = 32'd4; // Link value is pca + 4

endpackage

// File: instrDecoder.sv
// ----------------------------------------------------------
// Combinational decoder for the integer instruction subset
// ----------------------------------------------------------
`timescale 1ns/1ps

module instrDecoder (
	input  isaPkg::instrT                     instr,
	output pipePkg::ctrlT                     ctrl,
	output logic [isaPkg::regAddrWidth-1:0]   rs,
	output logic [isaPkg::regAddrWidth-1:0]   rt,
	output logic [isaPkg::regAddrWidth-1:0]   destReg,
	output logic [isaPkg::dataWidth-1:0]      imm
);

	assign rs = instr.r.rs;
	assign rt = instr.r.rt;

	always_comb begin
		ctrl = '0; // Unknown codes decode as a NOP
		case (instr.r.opcode)
			isaPkg::opSpecial: begin
				ctrl.regDst   = 1'b1;
				ctrl.regWrite = 1'b1;
				case (instr.r.funct)
					isaPkg::fnSll:  ctrl.aluOp = pipePkg::aluSll;
					isaPkg::fnSrl:  ctrl.aluOp = pipePkg::aluSrl;
					isaPkg::fnSra:  ctrl.aluOp = pipePkg::aluSra;
					isaPkg::fnAdd:  ctrl.aluOp = pipePkg::aluAdd;
					isaPkg::fnAddu: ctrl.aluOp = pipePkg::aluAddu;
					isaPkg::fnSub:  ctrl.aluOp = pipePkg::aluSub;
					isaPkg::fnSubu: ctrl.aluOp = pipePkg::aluSubu;
					isaPkg::fnAnd:  ctrl.aluOp = pipePkg::aluAnd;
					isaPkg::fnOr:   ctrl.aluOp = pipePkg::aluOr;
					isaPkg::fnXor:  ctrl.aluOp = pipePkg::aluXor;
					isaPkg::fnNor:  ctrl.aluOp = pipePkg::aluNor;
					isaPkg::fnSlt:  ctrl.aluOp = pipePkg::aluSlt;
					isaPkg::fnSltu: ctrl.aluOp = pipePkg::aluSltu;
					isaPkg::fnJr: begin
						ctrl.regDst   = 1'b0;
						ctrl.regWrite = 1'b0;
						ctrl.jump     = 1'b1;
						ctrl.jumpReg  = 1'b1;
					end
					isaPkg::fnJalr: begin
						ctrl.regDst  = 1'b0; // Links through r31
						ctrl.link    = 1'b1;
						ctrl.jump    = 1'b1;
						ctrl.jumpReg = 1'b1;
						ctrl.aluOp   = pipePkg::aluAdd;
					end
					isaPkg::fnSyscall: begin
						ctrl.regDst   = 1'b0;
						ctrl.regWrite = 1'b0;
						ctrl.syscall  = 1'b1;
						ctrl.aluOp    = pipePkg::aluAdd; // Passes the v0 argument on
					end
					default: ctrl = '0;
				endcase
			end
			isaPkg::opRegimm: begin
				if (instr.i.rt == isaPkg::rtBltz || instr.i.rt == isaPkg::rtBgez) begin
					ctrl.branch  = 1'b1;
					ctrl.signExt = 1'b1;
				end
			end
			isaPkg::opBeq, isaPkg::opBne, isaPkg::opBlez, isaPkg::opBgtz: begin
				ctrl.branch  = 1'b1;
				ctrl.signExt = 1'b1; // Signed word offset
			end
			isaPkg::opJ: ctrl.jump = 1'b1;
			isaPkg::opJal: begin
				ctrl.link     = 1'b1;
				ctrl.jump     = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = pipePkg::aluAdd;
			end
			isaPkg::opLw: begin
				ctrl.memRead  = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.signExt  = 1'b1;
				ctrl.aluOp    = pipePkg::aluAdd;
			end
			isaPkg::opSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.signExt  = 1'b1;
				ctrl.aluOp    = pipePkg::aluAdd;
			end
			isaPkg::opAddi, isaPkg::opAddiu, isaPkg::opSlti, isaPkg::opAndi,
			isaPkg::opOri, isaPkg::opXori, isaPkg::opLui: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				// Logical immediates are zero-extended
				ctrl.signExt  = instr.i.opcode inside {isaPkg::opAddi, isaPkg::opAddiu,
					isaPkg::opSlti};
				case (instr.i.opcode)
					isaPkg::opAddi:  ctrl.aluOp = pipePkg::aluAdd;
					isaPkg::opAddiu: ctrl.aluOp = pipePkg::aluAddu;
					isaPkg::opSlti:  ctrl.aluOp = pipePkg::aluSlt;
					isaPkg::opAndi:  ctrl.aluOp = pipePkg::aluAnd;
					isaPkg::opOri:   ctrl.aluOp = pipePkg::aluOr;
					isaPkg::opXori:  ctrl.aluOp = pipePkg::aluXor;
					default:         ctrl.aluOp = pipePkg::aluLui;
				endcase
			end
			default: ctrl = '0;
		endcase
	end

	always_comb begin
		if (ctrl.regDst)
			destReg = instr.r.rd;
		else if (ctrl.link)
			destReg = isaPkg::linkReg;
		else if (ctrl.syscall)
			destReg = '0;
		else
			destReg = instr.i.rt;
	end

	assign imm = ctrl.signExt ? {{(isaPkg::dataWidth-16){instr.i.imm[15]}}, instr.i.imm}
		: {{(isaPkg::dataWidth-16){1'b0}}, instr.i.imm};

	// Fetch redirect logic relies on jumps never being branches
	always_comb begin
		assert (!(ctrl.jump && ctrl.branch)) else $error("Decode set jump and branch together");
	end

endmodule

// File: regFile.sv
// ----------------------------------------------------------
// 32 x 32 register file, two read ports plus a v0 tap
// ----------------------------------------------------------
`timescale 1ns/1ps

module regFile (
	input  logic                              CLK,
	input  logic [isaPkg::regAddrWidth-1:0]   rs,
	input  logic [isaPkg::regAddrWidth-1:0]   rt,
	input  pipePkg::fwdT                      wbWrite,
	output logic [isaPkg::dataWidth-1:0]      rsData,
	output logic [isaPkg::dataWidth-1:0]      rtData,
	output logic [isaPkg::dataWidth-1:0]      r2Data
);

	logic [isaPkg::dataWidth-1:0] regs [isaPkg::regCount];

	// Reads return the old value in the writing cycle
	assign rsData = regs[rs];
	assign rtData = regs[rt];
	assign r2Data = regs[isaPkg::syscallArgReg]; // Syscall argument

	always_ff @(posedge CLK) begin
		if (wbWrite.valid)
			regs[wbWrite.regAddr] <= wbWrite.data;
	end

endmodule

// File: operandForward.sv
// ----------------------------------------------------------
// Comparison operand forwarding from EX, MEM and WB
// ----------------------------------------------------------
`timescale 1ns/1ps

module operandForward (
	input  logic [isaPkg::regAddrWidth-1:0]   rs,
	input  logic [isaPkg::regAddrWidth-1:0]   rt,
	input  pipePkg::fwdT                      exFwd,
	input  pipePkg::fwdT                      memFwd,
	input  pipePkg::fwdT                      wbFwd,
	input  logic [isaPkg::dataWidth-1:0]      rsData,
	input  logic [isaPkg::dataWidth-1:0]      rtData,
	output logic [isaPkg::dataWidth-1:0]      cmpA,
	output logic [isaPkg::dataWidth-1:0]      cmpB
);

	// Youngest producer wins, register 0 included
	function automatic logic [isaPkg::dataWidth-1:0] resolve(
		input logic [isaPkg::regAddrWidth-1:0] r,
		input logic [isaPkg::dataWidth-1:0]    fileData
	);
		if (exFwd.valid && exFwd.regAddr == r)
			return exFwd.data;
		if (memFwd.valid && memFwd.regAddr == r)
			return memFwd.data;
		if (wbFwd.valid && wbFwd.regAddr == r)
			return wbFwd.data;
		return fileData;
	endfunction

	always_comb begin
		cmpA = resolve(rs, rsData);
		cmpB = resolve(rt, rtData);
	end

	// A valid producer upstream must deliver defined data
	always_comb begin
		if (exFwd.valid === 1'b1)
			assert (!$isunknown(exFwd.data)) else $error("EX forward data is X");
		if (memFwd.valid === 1'b1)
			assert (!$isunknown(memFwd.data)) else $error("MEM forward data is X");
		if (wbFwd.valid === 1'b1)
			assert (!$isunknown(wbFwd.data)) else $error("WB forward data is X");
	end

endmodule

// File: branchUnit.sv
// ----------------------------------------------------------
// Branch conditions, jump targets and fetch redirect
// ----------------------------------------------------------
`timescale 1ns/1ps

module branchUnit (
	input  pipePkg::ctrlT                  ctrl,
	input  isaPkg::instrT                  instr,
	input  logic [isaPkg::dataWidth-1:0]   cmpA,
	input  logic [isaPkg::dataWidth-1:0]   cmpB,
	input  logic [isaPkg::dataWidth-1:0]   imm,
	input  logic [isaPkg::dataWidth-1:0]   pca,
	input  logic [isaPkg::dataWidth-1:0]   cia,
	output logic                           redirect,
	output logic [isaPkg::dataWidth-1:0]   nextAddr
);

	logic condMet;
	logic taken;

	always_comb begin
		case (instr.i.opcode)
			isaPkg::opBeq:  condMet = (cmpA == cmpB);
			isaPkg::opBne:  condMet = (cmpA != cmpB);
			isaPkg::opBlez: condMet = ($signed(cmpA) <= 0);
			isaPkg::opBgtz: condMet = ($signed(cmpA) > 0);
			isaPkg::opRegimm: begin
				if (instr.i.rt == isaPkg::rtBgez)
					condMet = ($signed(cmpA) >= 0);
				else
					condMet = ($signed(cmpA) < 0); // BLTZ
			end
			default: condMet = 1'b0;
		endcase
	end

	assign taken    = ctrl.branch && condMet;
	assign redirect = ctrl.jump || taken;

	always_comb begin
		if (ctrl.jump && ctrl.jumpReg)
			nextAddr = cmpA;                                  // JR, JALR
		else if (ctrl.jump)
			nextAddr = {cia[31:28], instr.j.target, 2'b00};   // Same 256 MB region
		else if (taken)
			nextAddr = pca + (imm << 2);
		else
			nextAddr = pca;
	end

endmodule

// File: idExRegister.sv
// ----------------------------------------------------------
// SYSCALL bubble counter and the ID/EX pipeline register
// ----------------------------------------------------------
`timescale 1ns/1ps

module idExRegister #(
	parameter int syscallBubbles = 3
) (
	input  logic                              CLK,
	input  logic                              RESET,
	input  logic                              FREEZE,
	input  pipePkg::ctrlT                     ctrl,
	input  logic [isaPkg::regAddrWidth-1:0]   rs,
	input  logic [isaPkg::regAddrWidth-1:0]   rt,
	input  logic [isaPkg::regAddrWidth-1:0]   destReg,
	input  logic [isaPkg::dataWidth-1:0]      imm,
	input  logic [4:0]                        shamt,
	input  logic [isaPkg::dataWidth-1:0]      rsData,
	input  logic [isaPkg::dataWidth-1:0]      rtData,
	input  logic [isaPkg::dataWidth-1:0]      r2Data,
	input  logic [isaPkg::dataWidth-1:0]      pca,
	input  logic [isaPkg::dataWidth-1:0]      r2Input,
	input  logic [isaPkg::dataWidth-1:0]      nextAddr,
	output logic                              insertBubble,
	output logic                              sysStrobe,
	output pipePkg::idExT                     idEx,
	output logic [isaPkg::dataWidth-1:0]      nextPc,
	output logic [isaPkg::dataWidth-1:0]      r2Value
);

	localparam int cntWidth = (syscallBubbles > 0) ? $clog2(syscallBubbles + 1) : 1;
	localparam logic [cntWidth-1:0] cntReload = cntWidth'(syscallBubbles);

	logic [cntWidth-1:0] bubbleCnt;
	pipePkg::idExT       bundle;

	// ----------------------------------------------------------
	// SYSCALL sequence
	// ----------------------------------------------------------
	assign insertBubble = ctrl.syscall && (bubbleCnt != '0);
	assign sysStrobe    = ctrl.syscall && (bubbleCnt == '0);

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			bubbleCnt <= cntReload;
		end else if (!FREEZE) begin
			if (!ctrl.syscall || bubbleCnt == '0)
				bubbleCnt <= cntReload; // Idle or strobe done
			else
				bubbleCnt <= bubbleCnt - 1'b1;
		end
	end

	// ----------------------------------------------------------
	// Next bundle
	// ----------------------------------------------------------
	always_comb begin
		bundle = '0;
		if (ctrl.link)
			bundle.operandA = pca;
		else if (ctrl.syscall)
			bundle.operandA = r2Input;
		else
			bundle.operandA = rsData;

		if (ctrl.link)
			bundle.operandB = pipePkg::linkOffset;
		else if (ctrl.syscall)
			bundle.operandB = '0;
		else if (ctrl.aluSrc)
			bundle.operandB = imm;
		else
			bundle.operandB = rtData;

		bundle.storeData   = rtData;
		// Sources that are not read must not trigger EX forwarding
		bundle.srcRegA     = (ctrl.link || ctrl.syscall) ? '0 : rs;
		bundle.srcRegB     = (ctrl.aluSrc || ctrl.link || ctrl.syscall) ? '0 : rt;
		bundle.destReg     = destReg;
		bundle.doWriteback = ctrl.regWrite && (destReg != '0);
		bundle.memRead     = ctrl.memRead;
		bundle.memWrite    = ctrl.memWrite;
		bundle.memToReg    = ctrl.memToReg;
		bundle.aluOp       = ctrl.aluOp;
		bundle.aluSrc      = ctrl.aluSrc;
		bundle.shamt       = shamt;
	end

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			idEx    <= '0;
			nextPc  <= '0;
			r2Value <= '0;
		end else if (!FREEZE) begin
			if (insertBubble) begin
				idEx   <= '0;
				nextPc <= '0;
			end else begin
				idEx   <= bundle;
				nextPc <= nextAddr;
			end
			r2Value <= r2Data;
		end
	end

	// The v0 argument only reaches operandA when no link or write rides along
	assert property (@(posedge CLK) disable iff (!RESET)
		ctrl.syscall |-> !(ctrl.link || ctrl.regWrite || ctrl.memWrite))
		else $error("SYSCALL decoded with a link, register write or memory write");

endmodule

// File: idStage.sv
// ----------------------------------------------------------
// Instruction decode stage top level
// ----------------------------------------------------------
`timescale 1ns/1ps

module idStage #(
	parameter int syscallBubbles = 3
) (
	input  logic                          CLK,
	input  logic                          RESET,
	input  logic                          FREEZE,
	input  isaPkg::instrT                 instr,
	input  logic [isaPkg::dataWidth-1:0]  pca,      // Address after instr
	input  logic [isaPkg::dataWidth-1:0]  cia,
	input  logic [isaPkg::dataWidth-1:0]  exResult,
	input  pipePkg::fwdT                  memFwd,
	input  pipePkg::fwdT                  wbWrite,  // Register write and WB forward
	input  logic [isaPkg::dataWidth-1:0]  r2Input,
	output pipePkg::idExT                 idEx,
	output logic [isaPkg::dataWidth-1:0]  nextPc,
	output logic [isaPkg::dataWidth-1:0]  r2Value,
	output logic                          redirect,
	output logic                          insertBubble,
	output logic                          sysStrobe
);

	pipePkg::ctrlT                     ctrl;
	pipePkg::fwdT                      exFwd;
	logic [isaPkg::regAddrWidth-1:0]   rs;
	logic [isaPkg::regAddrWidth-1:0]   rt;
	logic [isaPkg::regAddrWidth-1:0]   destReg;
	logic [isaPkg::dataWidth-1:0]      imm;
	logic [isaPkg::dataWidth-1:0]      rsData;
	logic [isaPkg::dataWidth-1:0]      rtData;
	logic [isaPkg::dataWidth-1:0]      r2Data;
	logic [isaPkg::dataWidth-1:0]      cmpA;
	logic [isaPkg::dataWidth-1:0]      cmpB;
	logic [isaPkg::dataWidth-1:0]      nextAddr;

	// Instruction now in EX
	assign exFwd.valid   = idEx.doWriteback;
	assign exFwd.regAddr = idEx.destReg;
	assign exFwd.data    = exResult;

	instrDecoder u_decoder (
		.instr(instr), .ctrl(ctrl), .rs(rs), .rt(rt), .destReg(destReg), .imm(imm)
	);

	regFile u_regFile (
		.CLK(CLK), .rs(rs), .rt(rt), .wbWrite(wbWrite),
		.rsData(rsData), .rtData(rtData), .r2Data(r2Data)
	);

	operandForward u_forward (
		.rs(rs), .rt(rt), .exFwd(exFwd), .memFwd(memFwd), .wbFwd(wbWrite),
		.rsData(rsData), .rtData(rtData), .cmpA(cmpA), .cmpB(cmpB)
	);

	branchUnit u_branch (
		.ctrl(ctrl), .instr(instr), .cmpA(cmpA), .cmpB(cmpB), .imm(imm),
		.pca(pca), .cia(cia), .redirect(redirect), .nextAddr(nextAddr)
	);

	idExRegister #(.syscallBubbles(syscallBubbles)) u_idExReg (
		.CLK(CLK), .RESET(RESET), .FREEZE(FREEZE), .ctrl(ctrl),
		.rs(rs), .rt(rt), .destReg(destReg), .imm(imm), .shamt(instr.r.shamt),
		.rsData(rsData), .rtData(rtData), .r2Data(r2Data),
		.pca(pca), .r2Input(r2Input), .nextAddr(nextAddr),
		.insertBubble(insertBubble), .sysStrobe(sysStrobe),
		.idEx(idEx), .nextPc(nextPc), .r2Value(r2Value)
	);

endmodule

// File: tbModel.svh
// ----------------------------------------------------------
// Reference model of the decode stage: register mirror,
// decode, forwarding, branch targets and the bubble counter
// ----------------------------------------------------------
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [31:0]   mRegs [32];  // Register file mirror
pipePkg::idExT mIdEx;       // Expected ID/EX contents
logic [31:0]   mNextPc;
logic [31:0]   mR2;
int            mCnt;        // Bubble counter
logic          mRedirect;
logic          mBubble;
logic          mStrobe;

// Kept SPECIAL ALU functions and the ALU op each one means
isaPkg::functT rFuncts [13] = '{isaPkg::fnSll, isaPkg::fnSrl, isaPkg::fnSra, isaPkg::fnAdd,
	isaPkg::fnAddu, isaPkg::fnSub, isaPkg::fnSubu, isaPkg::fnAnd, isaPkg::fnOr,
	isaPkg::fnXor, isaPkg::fnNor, isaPkg::fnSlt, isaPkg::fnSltu};
pipePkg::aluOpT rOps [13] = '{pipePkg::aluSll, pipePkg::aluSrl, pipePkg::aluSra,
	pipePkg::aluAdd, pipePkg::aluAddu, pipePkg::aluSub, pipePkg::aluSubu, pipePkg::aluAnd,
	pipePkg::aluOr, pipePkg::aluXor, pipePkg::aluNor, pipePkg::aluSlt, pipePkg::aluSltu};
// Immediates, the first three sign-extend
isaPkg::opcodeT iOpcodes [7] = '{isaPkg::opAddi, isaPkg::opAddiu, isaPkg::opSlti,
	isaPkg::opAndi, isaPkg::opOri, isaPkg::opXori, isaPkg::opLui};
pipePkg::aluOpT iOps [7] = '{pipePkg::aluAdd, pipePkg::aluAddu, pipePkg::aluSlt,
	pipePkg::aluAnd, pipePkg::aluOr, pipePkg::aluXor, pipePkg::aluLui};

function automatic pipePkg::ctrlT decodeRef(input isaPkg::instrT i);
	pipePkg::ctrlT c;
	c = '0;
	case (i.r.opcode)
		isaPkg::opSpecial: begin
			if (i.r.funct == isaPkg::fnJr || i.r.funct == isaPkg::fnJalr) begin
				c.jump     = 1'b1;
				c.jumpReg  = 1'b1;
				c.link     = (i.r.funct == isaPkg::fnJalr);
				c.regWrite = c.link;
				c.aluOp    = c.link ? pipePkg::aluAdd : pipePkg::aluPass;
			end else if (i.r.funct == isaPkg::fnSyscall) begin
				c.syscall = 1'b1;
				c.aluOp   = pipePkg::aluAdd;
			end else begin
				for (int k = 0; k < 13; k++) begin
					if (rFuncts[k] == i.r.funct) begin
						c.regDst   = 1'b1;
						c.regWrite = 1'b1;
						c.aluOp    = rOps[k];
					end
				end
			end
		end
		isaPkg::opRegimm, isaPkg::opBeq, isaPkg::opBne, isaPkg::opBlez, isaPkg::opBgtz: begin
			c.branch  = (i.i.opcode != isaPkg::opRegimm) || (i.i.rt < 5'd2);
			c.signExt = c.branch;
		end
		isaPkg::opJ: c.jump = 1'b1;
		isaPkg::opJal: begin
			c.jump     = 1'b1;
			c.link     = 1'b1;
			c.regWrite = 1'b1;
			c.aluOp    = pipePkg::aluAdd;
		end
		isaPkg::opLw, isaPkg::opSw: begin
			c.memRead  = (i.i.opcode == isaPkg::opLw);
			c.memToReg = c.memRead;
			c.regWrite = c.memRead;
			c.memWrite = !c.memRead;
			c.aluSrc   = 1'b1;
			c.signExt  = 1'b1;
			c.aluOp    = pipePkg::aluAdd;
		end
		default: begin
			for (int k = 0; k < 7; k++) begin
				if (iOpcodes[k] == i.i.opcode) begin
					c.aluSrc   = 1'b1;
					c.regWrite = 1'b1;
					c.signExt  = (k < 3);
					c.aluOp    = iOps[k];
				end
			end
		end
	endcase
	return c;
endfunction

// EX beats MEM beats WB
function automatic logic [31:0] fwdRef(input logic [4:0] r, input logic [31:0] fileVal);
	if (mIdEx.doWriteback && mIdEx.destReg == r)
		return exResult;
	if (memFwd.valid && memFwd.regAddr == r)
		return memFwd.data;
	if (wbWrite.valid && wbWrite.regAddr == r)
		return wbWrite.data;
	return fileVal;
endfunction

// Predicts this cycle's strobes, then advances the state by one edge
task automatic stepModel();
	pipePkg::ctrlT c;
	pipePkg::idExT nb;
	logic [31:0]   imm;
	logic [31:0]   a;
	logic [31:0]   b;
	logic [31:0]   target;
	logic [4:0]    dst;
	logic          cond;
	c   = decodeRef(instr);
	imm = c.signExt ? {{16{instr.i.imm[15]}}, instr.i.imm} : {16'h0, instr.i.imm};
	dst = c.regDst ? instr.r.rd : (c.link ? 5'd31 : (c.syscall ? 5'd0 : instr.i.rt));
	a   = fwdRef(instr.r.rs, mRegs[instr.r.rs]);
	b   = fwdRef(instr.r.rt, mRegs[instr.r.rt]);
	case (instr.i.opcode)
		isaPkg::opBeq:  cond = (a == b);
		isaPkg::opBne:  cond = (a != b);
		isaPkg::opBlez: cond = ($signed(a) <= 0);
		isaPkg::opBgtz: cond = ($signed(a) > 0);
		default:        cond = instr.i.rt[0] ? ($signed(a) >= 0) : ($signed(a) < 0);
	endcase
	cond      = cond && c.branch;
	mRedirect = c.jump || cond;
	if (c.jumpReg)
		target = a;
	else if (c.jump)
		target = {cia[31:28], instr.j.target, 2'b00};
	else if (cond)
		target = pca + (imm << 2);
	else
		target = pca;
	mBubble = c.syscall && (mCnt != 0);
	mStrobe = c.syscall && (mCnt == 0);

	nb = '0;
	nb.operandA    = c.link ? pca : (c.syscall ? r2Input : mRegs[instr.r.rs]);
	nb.operandB    = c.link ? 32'd4 : (c.syscall ? 32'd0 : (c.aluSrc ? imm : mRegs[instr.r.rt]));
	nb.storeData   = mRegs[instr.r.rt];
	nb.srcRegA     = (c.link || c.syscall) ? 5'd0 : instr.r.rs;
	nb.srcRegB     = (c.aluSrc || c.link || c.syscall) ? 5'd0 : instr.r.rt;
	nb.destReg     = dst;
	nb.doWriteback = c.regWrite && (dst != 5'd0);
	nb.memRead     = c.memRead;
	nb.memWrite    = c.memWrite;
	nb.memToReg    = c.memToReg;
	nb.aluOp       = c.aluOp;
	nb.aluSrc      = c.aluSrc;
	nb.shamt       = instr.r.shamt;

	if (!FREEZE) begin
		mIdEx   = mBubble ? '0 : nb;
		mNextPc = mBubble ? 32'd0 : target;
		mR2     = mRegs[2];
		mCnt    = (!c.syscall || mCnt == 0) ? syscallBubbles : mCnt - 1;
	end
	if (wbWrite.valid)
		mRegs[wbWrite.regAddr] = wbWrite.data; // Write lands even when frozen
endtask

`endif

// File: tbIdStage.sv
// ----------------------------------------------------------
// Testbench for the decode stage: random traffic checked
// against the reference model, timeout and summary
// ----------------------------------------------------------
`timescale 1ns/1ps

module tbIdStage;

	localparam int syscallBubbles = 3;
	localparam int resetCycles    = 5;
	localparam int startCycles    = 2;
	localparam int fillCycles     = 32 + 200; // Every register, then random write-backs
	localparam int aluCycles      = 200;
	localparam int branchCycles   = 300;
	localparam int sysCycles      = syscallBubbles + 2;
	localparam int freezeCycles   = 300;
	localparam int memCycles      = 100;
	localparam int cycleLimit     = resetCycles + startCycles + fillCycles + aluCycles
		+ branchCycles + sysCycles + freezeCycles + memCycles + 100;

	logic                CLK;
	logic                RESET;
	logic                FREEZE;
	isaPkg::instrT       instr;
	logic [31:0]         pca;
	logic [31:0]         cia;
	logic [31:0]         exResult;
	pipePkg::fwdT        memFwd;
	pipePkg::fwdT        wbWrite;
	logic [31:0]         r2Input;
	pipePkg::idExT       idEx;
	logic [31:0]         nextPc;
	logic [31:0]         r2Value;
	logic                redirect;
	logic                insertBubble;
	logic                sysStrobe;

	int errors     = 0;
	int checks     = 0;
	int testStart  = 0;
	int cycleCount = 0;

	`include "tbModel.svh"

	idStage #(.syscallBubbles(syscallBubbles)) u_idStage (
		.CLK(CLK), .RESET(RESET), .FREEZE(FREEZE), .instr(instr), .pca(pca), .cia(cia),
		.exResult(exResult), .memFwd(memFwd), .wbWrite(wbWrite), .r2Input(r2Input),
		.idEx(idEx), .nextPc(nextPc), .r2Value(r2Value), .redirect(redirect),
		.insertBubble(insertBubble), .sysStrobe(sysStrobe)
	);

	always #10 CLK = ~CLK;

	// Watchdog
	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Run timed out after %0d cycles without finishing the tests", cycleCount);
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s got=%h exp=%h at %0t", name, got, exp, $time);
		end
	endtask

	function automatic pipePkg::fwdT randomFwd();
		pipePkg::fwdT f;
		f.valid   = 1'($urandom_range(1));
		f.regAddr = 5'($urandom);
		f.data    = $urandom;
		return f;
	endfunction

	// Kind 0 ALU, 1 branch or jump, 2 load or store, 3 any, 4 SYSCALL
	function automatic isaPkg::instrT randInstr(input int kind);
		isaPkg::instrT w;
		int            sel;
		int            pick;
		w   = $urandom;
		sel = kind;
		if (sel == 3)
			sel = ($urandom_range(7) == 0) ? 4 : int'($urandom_range(2));
		case (sel)
			0: begin
				pick = $urandom_range(19);
				if (pick < 13) begin
					w.r.opcode = isaPkg::opSpecial;
					w.r.funct  = rFuncts[pick];
				end else begin
					w.i.opcode = iOpcodes[pick-13];
				end
			end
			1: begin
				pick = $urandom_range(9);
				case (pick)
					0: w.i.opcode = isaPkg::opBeq;
					1: w.i.opcode = isaPkg::opBne;
					2: w.i.opcode = isaPkg::opBlez;
					3: w.i.opcode = isaPkg::opBgtz;
					4, 5: begin
						w.i.opcode = isaPkg::opRegimm;
						w.i.rt     = 5'(pick - 4); // BLTZ or BGEZ
					end
					6: w.j.opcode = isaPkg::opJ;
					7: w.j.opcode = isaPkg::opJal;
					default: begin
						w.r.opcode = isaPkg::opSpecial;
						w.r.funct  = (pick == 8) ? isaPkg::fnJr : isaPkg::fnJalr;
					end
				endcase
			end
			2: w.i.opcode = $urandom_range(1) ? isaPkg::opLw : isaPkg::opSw;
			default: begin
				w.r.opcode = isaPkg::opSpecial;
				w.r.funct  = isaPkg::fnSyscall;
			end
		endcase
		return w;
	endfunction

	task automatic checkRegistered();
		compare("idEx.operandA", idEx.operandA, mIdEx.operandA);
		compare("idEx.operandB", idEx.operandB, mIdEx.operandB);
		compare("idEx.storeData", idEx.storeData, mIdEx.storeData);
		compare("idEx.srcRegA", idEx.srcRegA, mIdEx.srcRegA);
		compare("idEx.srcRegB", idEx.srcRegB, mIdEx.srcRegB);
		compare("idEx.destReg", idEx.destReg, mIdEx.destReg);
		compare("idEx.doWriteback", idEx.doWriteback, mIdEx.doWriteback);
		compare("idEx.memRead", idEx.memRead, mIdEx.memRead);
		compare("idEx.memWrite", idEx.memWrite, mIdEx.memWrite);
		compare("idEx.memToReg", idEx.memToReg, mIdEx.memToReg);
		compare("idEx.aluOp", idEx.aluOp, mIdEx.aluOp);
		compare("idEx.aluSrc", idEx.aluSrc, mIdEx.aluSrc);
		compare("idEx.shamt", idEx.shamt, mIdEx.shamt);
		compare("nextPc", nextPc, mNextPc);
		compare("r2Value", r2Value, mR2);
	endtask

	// One clock: drive on the rising edge, check at the falling edge
	task automatic runCycle(input isaPkg::instrT i, input logic frz, input pipePkg::fwdT wb);
		@(posedge CLK);
		instr    <= i;
		FREEZE   <= frz;
		pca      <= $urandom;
		cia      <= $urandom;
		exResult <= $urandom;
		memFwd   <= randomFwd();
		wbWrite  <= wb;
		r2Input  <= $urandom;
		@(negedge CLK);
		checkRegistered();
		stepModel();
		compare("redirect", redirect, mRedirect);
		compare("insertBubble", insertBubble, mBubble);
		compare("sysStrobe", sysStrobe, mStrobe);
	endtask

	task automatic endTest(input int num, input string name);
		$display("Test %0d (%s) finished with %0d errors", num, name, errors - testStart);
		testStart = errors;
	endtask

	initial begin
		pipePkg::fwdT wb;
		int           freezeLeft;
		int           bubbles;
		int           strobes;
		void'($urandom(32'h9778));
		CLK      = 1'b0;
		RESET    = 1'b0;
		FREEZE   = 1'b1; // Held until the registers are filled
		instr    = '0;
		pca      = '0;
		cia      = '0;
		exResult = '0;
		memFwd   = '0;
		wbWrite  = '0;
		r2Input  = '0;
		mIdEx    = '0;
		mNextPc  = '0;
		mR2      = '0;
		mCnt     = syscallBubbles;
		repeat (resetCycles) @(posedge CLK);
		RESET <= 1'b1;

		// 1: state straight after reset
		repeat (startCycles) runCycle('0, 1'b1, '0);
		compare("idEx.doWriteback", idEx.doWriteback, 1'b0);
		compare("idEx.memRead", idEx.memRead, 1'b0);
		compare("idEx.memWrite", idEx.memWrite, 1'b0);
		compare("nextPc", nextPc, 32'd0);
		compare("r2Value", r2Value, 32'd0);
		endTest(1, "reset state");

		// 2: fill the file while frozen, then ALU traffic
		for (int r = 0; r < 32; r++) begin
			wb.valid   = 1'b1;
			wb.regAddr = 5'(r);
			wb.data    = $urandom;
			runCycle('0, 1'b1, wb);
		end
		repeat (200) runCycle('0, 1'b1, randomFwd());
		repeat (aluCycles) runCycle(randInstr(0), 1'b0, randomFwd());
		endTest(2, "register file and ALU decode");

		// 3
		repeat (branchCycles) runCycle(randInstr(1), 1'b0, randomFwd());
		endTest(3, "branches, jumps and forwarding");

		// 4: hold SYSCALL through the bubbles and the strobe
		bubbles = 0;
		strobes = 0;
		for (int k = 0; k <= syscallBubbles; k++) begin
			runCycle(randInstr(4), 1'b0, randomFwd());
			bubbles += insertBubble;
			strobes += sysStrobe;
		end
		runCycle(randInstr(0), 1'b0, randomFwd()); // Strobe bundle reaches idEx
		compare("bubble count", bubbles, syscallBubbles);
		compare("strobe count", strobes, 1);
		endTest(4, "SYSCALL sequence");

		// 5: random freeze stretches over mixed traffic
		freezeLeft = 0;
		for (int k = 0; k < freezeCycles; k++) begin
			if (freezeLeft == 0 && $urandom_range(3) == 0)
				freezeLeft = $urandom_range(8, 1);
			runCycle(randInstr(3), freezeLeft > 0, randomFwd());
			if (freezeLeft > 0)
				freezeLeft--;
		end
		endTest(5, "freeze");

		// 6
		repeat (memCycles) runCycle(randInstr(2), 1'b0, randomFwd());
		endTest(6, "loads and stores");

		$display("Summary: 6 tests, %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+.
isaPkg.sv
pipePkg.sv
instrDecoder.sv
regFile.sv
operandForward.sv
branchUnit.sv
idExRegister.sv
idStage.sv
tbIdStage.sv

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tbIdStage \
	-o simIdStage
output=$(./obj_dir/simIdStage)
echo "$output"
echo "$output" | grep -q "TB PASSED"
